//--- logic/fibDataPkg.sv
package fibDataPkg;

    //////////////////////////////
    // datapath widths
    //////////////////////////////

    // one word on the A, B and write buses
    typedef logic [15:0] dataWord;
    // register index into four entries
    typedef logic [1:0] regAddr;
    typedef logic [1:0] aluOp;
    // term count N up to 255
    typedef logic [7:0] termCount;
    // {carry, zero, negative, low}
    typedef logic [3:0] flagWord;
    typedef logic writeSel;

    localparam int regCount = 4;

    // alu operation codes
    localparam aluOp aluAdd   = 2'd0;
    localparam aluOp aluPassA = 2'd1;
    localparam aluOp aluPassB = 2'd2;

    // flag bit positions
    localparam int flagCarry = 3;
    localparam int flagZero  = 2;
    localparam int flagNeg   = 1;
    localparam int flagLow   = 0;

    // results below this count as low
    localparam dataWord lowLimit = 16'd256;

    // write bus source
    localparam writeSel selSeed = 1'b0;
    localparam writeSel selAlu  = 1'b1;

endpackage

//--- logic/fibHostPkg.sv
package fibHostPkg;

    //////////////////////////////
    // host bus widths
    //////////////////////////////

    // word address of four registers
    typedef logic [1:0] wbAddr;
    typedef logic [15:0] wbData;

    //////////////////////////////
    // register map
    //////////////////////////////

    // bit 0 of ctrl written high starts a run
    localparam wbAddr addrCtrl   = 2'd0;
    localparam wbAddr addrCount  = 2'd1;
    localparam wbAddr addrStatus = 2'd2;
    localparam wbAddr addrResult = 2'd3;

    // status word layout
    localparam int busyBit   = 0;
    localparam int doneBit   = 1;
    localparam int flagShift = 4;

endpackage

//--- logic/fibDatapathIf.sv
`timescale 1ns/1ps

interface fibDatapathIf;
    import fibDataPkg::*;

    // read and write selects from the FSM
    regAddr readA;
    regAddr readB;
    regAddr writeAddr;
    logic writeEn;
    // seed constant or alu result onto the write bus
    writeSel srcSel;
    dataWord seedValue;
    aluOp op;
    logic flagLoad;
    logic flagClear;
    // result register captures busB in the finish cycle
    logic resultValid;

    // operand buses and alu output
    dataWord busA;
    dataWord busB;
    dataWord aluResult;

    modport ctrl (
        output readA, readB, writeAddr, writeEn, srcSel, seedValue,
        output op, flagLoad, flagClear, resultValid
    );

    modport regs (
        input readA, readB, writeAddr, writeEn, srcSel, seedValue,
        input resultValid, aluResult,
        output busA, busB
    );

    modport alu (
        input busA, busB, op, flagLoad, flagClear,
        output aluResult
    );

endinterface

//--- logic/fibControl.sv
`timescale 1ns/1ps

module fibControl (
    input  logic                clk,
    input  logic                rstN,
    input  logic                startPulse,
    input  fibDataPkg::termCount count,
    output logic                busy,
    output logic                done,
    fibDatapathIf.ctrl          dp
);
    import fibDataPkg::*;

    typedef enum logic [2:0] {
        idle,
        seedZero,
        seedOne,
        addLoop,
        finish
    } ctrlState;

    ctrlState state;
    // index i of the term being built
    termCount step;

    //////////////////////////////
    // state register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= idle;
            step  <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    // host port already drops starts while busy
                    if (startPulse) begin
                        state <= seedZero;
                        busy  <= 1'b1;
                        done  <= 1'b0;
                    end
                end
                seedZero: state <= seedOne;
                seedOne: begin
                    step <= termCount'(2);
                    // N of 0 or 1 needs no addition
                    if (count < termCount'(2)) begin
                        state <= finish;
                    end else begin
                        state <= addLoop;
                    end
                end
                addLoop: begin
                    if (step == count) begin
                        state <= finish;
                    end else begin
                        step <= step + termCount'(1);
                    end
                end
                finish: begin
                    state <= idle;
                    busy  <= 1'b0;
                    done  <= 1'b1;
                end
                default: state <= idle;
            endcase
        end
    end

    //////////////////////////////
    // datapath steering
    //////////////////////////////

    always_comb begin
        // quiet datapath by default
        dp.readA       = regAddr'(0);
        dp.readB       = regAddr'(1);
        dp.writeAddr   = regAddr'(0);
        dp.writeEn     = 1'b0;
        dp.srcSel      = selSeed;
        dp.seedValue   = '0;
        dp.op          = aluPassA;
        dp.flagLoad    = 1'b0;
        dp.flagClear   = 1'b0;
        dp.resultValid = 1'b0;
        case (state)
            idle: begin
                // flags from the previous run go away on start
                dp.flagClear = startPulse;
            end
            seedZero: begin
                dp.writeAddr = regAddr'(0);
                dp.seedValue = dataWord'(0);
                dp.writeEn   = 1'b1;
            end
            seedOne: begin
                dp.writeAddr = regAddr'(1);
                dp.seedValue = dataWord'(1);
                dp.writeEn   = 1'b1;
            end
            addLoop: begin
                // F(i) overwrites the older of the two terms
                dp.op        = aluAdd;
                dp.srcSel    = selAlu;
                dp.writeAddr = {1'b0, step[0]};
                dp.writeEn   = 1'b1;
                dp.flagLoad  = 1'b1;
            end
            finish: begin
                // F(N) sits at index N mod 2
                dp.readB       = {1'b0, count[0]};
                dp.resultValid = 1'b1;
            end
            default: begin
                dp.writeEn = 1'b0;
            end
        endcase
    end

endmodule

//--- logic/fibRegFile.sv
`timescale 1ns/1ps

module fibRegFile (
    input  logic               clk,
    input  logic               rstN,
    fibDatapathIf.regs         dp,
    output fibDataPkg::dataWord result
);
    import fibDataPkg::*;

    dataWord regs [regCount];
    dataWord writeBus;

    //////////////////////////////
    // write path
    //////////////////////////////

    // seed constant from the FSM or the alu sum
    assign writeBus = (dp.srcSel == selAlu) ? dp.aluResult : dp.seedValue;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (dp.writeEn) begin
            regs[dp.writeAddr] <= writeBus;
        end
    end

    //////////////////////////////
    // read ports
    //////////////////////////////

    // both combinational in the select cycle
    assign dp.busA = regs[dp.readA];
    assign dp.busB = regs[dp.readB];

    // keep F(N) for the host once the engine idles
    always_ff @(posedge clk) begin
        if (!rstN) begin
            result <= '0;
        end else if (dp.resultValid) begin
            result <= dp.busB;
        end
    end

endmodule

//--- logic/fibAlu.sv
`timescale 1ns/1ps

module fibAlu (
    input  logic               clk,
    input  logic               rstN,
    fibDatapathIf.alu          dp,
    output fibDataPkg::flagWord flags
);
    import fibDataPkg::*;

    // top bit is the carry out
    logic [16:0] sum;
    logic carryOut;
    flagWord nextFlags;

    //////////////////////////////
    // operation
    //////////////////////////////

    assign sum = {1'b0, dp.busA} + {1'b0, dp.busB};

    always_comb begin
        carryOut = 1'b0;
        case (dp.op)
            aluAdd: begin
                dp.aluResult = sum[15:0];
                carryOut     = sum[16];
            end
            aluPassA: dp.aluResult = dp.busA;
            aluPassB: dp.aluResult = dp.busB;
            default:  dp.aluResult = '0;
        endcase
    end

    // flags of the current result
    always_comb begin
        nextFlags            = '0;
        nextFlags[flagCarry] = carryOut;
        nextFlags[flagZero]  = (dp.aluResult == '0);
        nextFlags[flagNeg]   = dp.aluResult[15];
        nextFlags[flagLow]   = (dp.aluResult < lowLimit);
    end

    //////////////////////////////
    // flag register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            flags <= '0;
        end else if (dp.flagClear) begin
            // clear wins over load at start
            flags <= '0;
        end else if (dp.flagLoad) begin
            flags <= nextFlags;
        end
    end

endmodule

//--- logic/fibHostPort.sv
`timescale 1ns/1ps

module fibHostPort (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    input  fibHostPkg::wbAddr    wbAdr,
    input  fibHostPkg::wbData    wbWriteData,
    output fibHostPkg::wbData    wbReadData,
    output logic                 wbAck,
    output logic                 startPulse,
    output fibDataPkg::termCount count,
    input  logic                 busy,
    input  logic                 done,
    input  fibDataPkg::flagWord  flags,
    input  fibDataPkg::dataWord  result
);
    import fibDataPkg::*;
    import fibHostPkg::*;

    // new access, not yet acknowledged
    logic access;
    logic writeOk;
    wbData status;

    assign access  = wbCyc && wbStb && !wbAck;
    // writes to ctrl or count land only while idle
    assign writeOk = access && wbWe && !busy;

    always_comb begin
        status                                  = '0;
        status[busyBit]                         = busy;
        status[doneBit]                         = done;
        status[flagShift +: $bits(flagWord)]    = flags;
    end

    //////////////////////////////
    // ack, start, count
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbAck      <= 1'b0;
            startPulse <= 1'b0;
            count      <= '0;
        end else begin
            // single wait state with ack high for one cycle
            wbAck      <= access;
            startPulse <= writeOk && (wbAdr == addrCtrl) && wbWriteData[0];
            if (writeOk && (wbAdr == addrCount)) begin
                count <= wbWriteData[$bits(termCount)-1:0];
            end
        end
    end

    //////////////////////////////
    // read data
    //////////////////////////////

    // only meaningful while wbAck is high
    always_ff @(posedge clk) begin
        if (access && !wbWe) begin
            case (wbAdr)
                addrCount:  wbReadData <= wbData'(count);
                addrStatus: wbReadData <= status;
                addrResult: wbReadData <= wbData'(result);
                default:    wbReadData <= '0;
            endcase
        end
    end

endmodule

//--- logic/fibCore.sv
`timescale 1ns/1ps

module fibCore (
    input  logic              clk,
    input  logic              rstN,
    input  logic              wbCyc,
    input  logic              wbStb,
    input  logic              wbWe,
    input  fibHostPkg::wbAddr wbAdr,
    input  fibHostPkg::wbData wbWriteData,
    output fibHostPkg::wbData wbReadData,
    output logic              wbAck
);
    import fibDataPkg::*;

    // host port to FSM
    logic startPulse;
    termCount count;
    logic busy;
    logic done;
    // datapath back to the host port
    flagWord flags;
    dataWord result;

    fibDatapathIf dp ();

    //////////////////////////////
    // host side
    //////////////////////////////

    fibHostPort i_fibHostPort (
        .clk(clk),
        .rstN(rstN),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbWriteData(wbWriteData),
        .wbReadData(wbReadData),
        .wbAck(wbAck),
        .startPulse(startPulse),
        .count(count),
        .busy(busy),
        .done(done),
        .flags(flags),
        .result(result)
    );

    //////////////////////////////
    // engine
    //////////////////////////////

    fibControl i_fibControl (
        .clk(clk),
        .rstN(rstN),
        .startPulse(startPulse),
        .count(count),
        .busy(busy),
        .done(done),
        .dp(dp.ctrl)
    );

    fibRegFile i_fibRegFile (
        .clk(clk),
        .rstN(rstN),
        .dp(dp.regs),
        .result(result)
    );

    fibAlu i_fibAlu (
        .clk(clk),
        .rstN(rstN),
        .dp(dp.alu),
        .flags(flags)
    );

endmodule

//--- sim/fibClockGen.sv
`timescale 1ns/1ps

module fibClockGen (
    output logic clk,
    output logic rstN
);
    // 40 ns period
    localparam real halfPeriod = 20.0;
    localparam int resetCycles = 3;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // reset held low for the first cycles and released on a rising edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

//--- sim/fibCoreTb.sv
`timescale 1ns/1ps

module fibCoreTb;
    import fibDataPkg::*;
    import fibHostPkg::*;

    localparam int goldenCount = 8;
    localparam int randomCount = 8;
    // reset, golden, busy, random, reread
    localparam int testTotal = 1 + goldenCount + 1 + randomCount + 1;
    localparam int cycleLimit = testTotal * (255 + 20) * 4;
    localparam int ackLimit = 4;
    localparam int pollLimit = 200;

    logic clk;
    logic rstN;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    wbAddr wbAdr;
    wbData wbWriteData;
    wbData wbReadData;
    logic wbAck;

    // N, F(N) and flags as three words per line
    logic [15:0] goldenMem [goldenCount * 3];
    int errorCount;
    int testErrorStart;
    int passCount;
    int failCount;
    int cycleCount;

    fibClockGen i_fibClockGen (
        .clk(clk),
        .rstN(rstN)
    );

    fibCore i_fibCore (
        .clk(clk),
        .rstN(rstN),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbWriteData(wbWriteData),
        .wbReadData(wbReadData),
        .wbAck(wbAck)
    );

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // F(N) mod 2^16 and the flags of the last addition
    function automatic void fibModel(input termCount n, output dataWord res,
                                     output flagWord flg);
        dataWord older;
        dataWord newer;
        logic [16:0] sum;
        older = '0;
        newer = dataWord'(1);
        flg = '0;
        // no addition for N of 0 or 1
        res = dataWord'(n);
        for (int i = 2; i <= int'(n); i++) begin
            sum = {1'b0, older} + {1'b0, newer};
            older = newer;
            newer = sum[15:0];
            flg[flagCarry] = sum[16];
            flg[flagZero] = (newer == '0);
            flg[flagNeg] = newer[15];
            flg[flagLow] = (newer < 16'd256);
            res = newer;
        end
    endfunction

    function automatic wbData expectStatus(input logic busyExp, input logic doneExp);
        wbData s;
        s = '0;
        s[busyBit] = busyExp;
        s[doneBit] = doneExp;
        return s;
    endfunction

    function automatic flagWord statusFlags(input wbData s);
        return s[flagShift +: $bits(flagWord)];
    endfunction

    //////////////////////////////
    // checks and reporting
    //////////////////////////////

    task automatic compareWord(input string name, input dataWord got, input dataWord exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%04h expected 0x%04h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic compareFlags(input string name, input flagWord got, input flagWord exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%01h expected 0x%01h", name, got, exp);
            errorCount++;
        end
    endtask

    // busy and done bits only
    task automatic compareStatus(input string name, input wbData got, input wbData exp);
        wbData mask;
        mask = expectStatus(1'b1, 1'b1);
        if ((got & mask) !== (exp & mask)) begin
            $display("MISMATCH %s: got 0x%04h expected 0x%04h", name, got & mask, exp & mask);
            errorCount++;
        end
    endtask

    task automatic beginTest();
        testErrorStart = errorCount;
    endtask

    task automatic endTest(input string name);
        if (errorCount == testErrorStart) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: failed with %0d errors", name, errorCount - testErrorStart);
        end
    endtask

    //////////////////////////////
    // wishbone master
    //////////////////////////////

    // one classic cycle held until ack, after which ack must drop
    task automatic busAccess(input logic write, input wbAddr addr, input wbData wdata,
                             output wbData rdata);
        int waitCycles;
        logic acked;
        waitCycles = 0;
        acked = 1'b0;
        rdata = '0;
        @(posedge clk);
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe <= write;
        wbAdr <= addr;
        wbWriteData <= wdata;
        while (!acked && waitCycles < ackLimit) begin
            @(negedge clk);
            waitCycles++;
            if (wbAck) begin
                acked = 1'b1;
                rdata = wbReadData;
            end
        end
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe <= 1'b0;
        if (!acked) begin
            $display("ERROR: no wbAck within %0d cycles at address %0d", ackLimit, addr);
            errorCount++;
        end else begin
            @(negedge clk);
            if (wbAck) begin
                $display("ERROR: wbAck stayed high past one cycle at address %0d", addr);
                errorCount++;
            end
        end
    endtask

    task automatic busWrite(input wbAddr addr, input wbData wdata);
        wbData unused;
        busAccess(1'b1, addr, wdata, unused);
    endtask

    task automatic busRead(input wbAddr addr, output wbData rdata);
        busAccess(1'b0, addr, '0, rdata);
    endtask

    //////////////////////////////
    // engine runs
    //////////////////////////////

    task automatic startRun(input termCount n);
        busWrite(addrCount, wbData'(n));
        busWrite(addrCtrl, wbData'(1));
    endtask

    // poll status until done
    task automatic waitDone(input termCount n, output logic finished);
        wbData rd;
        int polls;
        finished = 1'b0;
        polls = 0;
        while (!finished && polls < pollLimit) begin
            busRead(addrStatus, rd);
            polls++;
            finished = rd[doneBit];
        end
        if (!finished) begin
            $display("ERROR: done never set for N = %0d after %0d status reads", n, polls);
            errorCount++;
        end
    endtask

    task automatic checkRun(input termCount n, input dataWord expRes, input flagWord expFlags);
        wbData rd;
        logic finished;
        waitDone(n, finished);
        if (finished) begin
            busRead(addrResult, rd);
            compareWord("result", rd, expRes);
            busRead(addrStatus, rd);
            compareStatus("status", rd, expectStatus(1'b0, 1'b1));
            compareFlags("flags", statusFlags(rd), expFlags);
        end
    endtask

    //////////////////////////////
    // watchdog
    //////////////////////////////

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("ERROR: run did not finish within %0d cycles", cycleLimit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin : mainSeq
        wbData rd;
        termCount n;
        termCount lastN;
        termCount otherN;
        dataWord expRes;
        dataWord lastRes;
        flagWord expFlags;
        logic [31:0] lcgState;

        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe <= 1'b0;
        wbAdr <= '0;
        wbWriteData <= '0;
        errorCount = 0;
        testErrorStart = 0;
        passCount = 0;
        failCount = 0;
        lastN = '0;
        lastRes = '0;
        $readmemh("sim/fibGolden.txt", goldenMem);
        while (rstN !== 1'b1) @(posedge clk);

        // everything reads zero out of reset
        beginTest();
        busRead(addrStatus, rd);
        compareStatus("status", rd, expectStatus(1'b0, 1'b0));
        compareFlags("flags", statusFlags(rd), '0);
        busRead(addrCount, rd);
        compareWord("count", rd, '0);
        busRead(addrResult, rd);
        compareWord("result", rd, '0);
        endTest("reset values");

        for (int i = 0; i < goldenCount; i++) begin
            n = termCount'(goldenMem[3 * i]);
            expRes = goldenMem[3 * i + 1];
            expFlags = flagWord'(goldenMem[3 * i + 2]);
            beginTest();
            startRun(n);
            checkRun(n, expRes, expFlags);
            endTest($sformatf("golden N=%0d", n));
        end

        // second start and count write land while the longest golden N runs
        n = termCount'(goldenMem[3 * (goldenCount - 1)]);
        expRes = goldenMem[3 * (goldenCount - 1) + 1];
        expFlags = flagWord'(goldenMem[3 * (goldenCount - 1) + 2]);
        otherN = termCount'(5);
        beginTest();
        startRun(n);
        busRead(addrStatus, rd);
        compareStatus("status", rd, expectStatus(1'b1, 1'b0));
        busWrite(addrCount, wbData'(otherN));
        busWrite(addrCtrl, wbData'(1));
        checkRun(n, expRes, expFlags);
        busRead(addrCount, rd);
        compareWord("count", rd, dataWord'(n));
        endTest($sformatf("writes while busy N=%0d", n));

        lcgState = 32'hf421;
        for (int i = 0; i < randomCount; i++) begin
            lcgState = nextRandom(lcgState);
            n = termCount'(lcgState[23:16]);
            fibModel(n, expRes, expFlags);
            beginTest();
            startRun(n);
            checkRun(n, expRes, expFlags);
            endTest($sformatf("random N=%0d", n));
            lastN = n;
            lastRes = expRes;
        end

        // result register holds across a count write without a start
        otherN = lastN ^ termCount'(8'h5a);
        beginTest();
        busWrite(addrCount, wbData'(otherN));
        busRead(addrResult, rd);
        compareWord("result", rd, lastRes);
        busRead(addrCount, rd);
        compareWord("count", rd, dataWord'(otherN));
        endTest("result kept after count write");

        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (errorCount == 0 && failCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- sim/fibGolden.txt
// columns: N, F(N) mod 2^16, flags {carry,zero,negative,low}, all hex
// N of 0 and 1 run no addition, so their flags stay clear
00 0000 0
01 0001 0
02 0001 1
03 0002 1
0a 0037 1
18 b520 2
19 2511 8
1e b228 a

//--- fibCore.f
logic/fibDataPkg.sv
logic/fibHostPkg.sv
logic/fibDatapathIf.sv
logic/fibControl.sv
logic/fibRegFile.sv
logic/fibAlu.sv
logic/fibHostPort.sv
logic/fibCore.sv
sim/fibClockGen.sv
sim/fibCoreTb.sv

//--- runSim.sh
#!/bin/sh
# build with Verilator, run from the project root, keep the output in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -f fibCore.f --top-module fibCoreTb -o fibCoreTb \
    && ./obj_dir/fibCoreTb 2>&1 | tee sim.log \
    || echo "build or run step did not complete" | tee -a sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
